// ==== src/pat_isa_pkg.sv ====
package pat_isa_pkg;

	// ==================================================
	// instruction word layout
	// ==================================================
	localparam int I_WIDTH = 23;	// full instruction word

	// lsb position of each field
	localparam int RN = 20;	// source and destination register
	localparam int OPCODE_I8 = 8;	// first level opcode
	localparam int IMM8 = 0;
	localparam int OPCODE_I3 = 4;	// second level, only when OPCODE_I8 is the prefix
	localparam int IMM3 = 0;	// also register select and input select
	localparam int OPCODE_I0 = 0;	// third level, only when OPCODE_I3 is the prefix

	localparam int RN_WIDTH = 3;
	localparam int OPCODE_WIDTH = 4;
	localparam int IMM8_WIDTH = 8;
	localparam int IMM3_WIDTH = 3;
	// bits 19..12 are reserved and must be zero

	localparam logic [OPCODE_WIDTH-1:0] PREFIX = 4'b1111;	// escape to next level

	// ==================================================
	// opcodes, odd codes in the alu groups take a register operand
	// ==================================================
	typedef enum logic [3:0] {
		I8_ORI = 4'd0, I8_ORR = 4'd1, I8_ANDI = 4'd2, I8_ANDR = 4'd3,
		I8_ADDI = 4'd4, I8_ADDR = 4'd5, I8_SUBI = 4'd6, I8_SUBR = 4'd7,
		I8_LDI = 4'd8, I8_BF = 4'd13
	} opcode_i8_e;

	typedef enum logic [3:0] {
		I3_SHLZI = 4'd0, I3_SHLZR = 4'd1, I3_SHLOI = 4'd2, I3_SHLOR = 4'd3,
		I3_SHRZI = 4'd4, I3_SHRZR = 4'd5, I3_ASRI = 4'd6, I3_ASRR = 4'd7,
		I3_IN = 4'd8, I3_OUT = 4'd11
	} opcode_i3_e;

	typedef enum logic [3:0] {
		I0_NOT = 4'd0,
		I0_NOP = 4'd15
	} opcode_i0_e;

	// execute stage operation
	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_ADD, ALU_SUB,
		ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_ASR,
		ALU_PASS_B,	// ldi and in
		ALU_NOT
	} alu_op_e;

	// source of operand b
	typedef enum logic [1:0] {
		SEL_IMM, SEL_REG, SEL_INPUT
	} operand_sel_e;

	localparam logic [I_WIDTH-1:0] INSTR_NOP =
		{{(I_WIDTH-12){1'b0}}, PREFIX, PREFIX, 4'(I0_NOP)};	// 23'h000fff

endpackage

// ==== src/pat_cfg_pkg.sv ====
package pat_cfg_pkg;

	// ==================================================
	// machine sizes
	// ==================================================
	localparam int D_WIDTH = 8;	// data path width
	localparam int I_ADR_WIDTH = 10;	// fetch address width, 1k instructions
	localparam int REG_COUNT = 8;	// fixed by the 3 bit rn field

	// ==================================================
	// branch handling
	// ==================================================
	// when a branch is in execute three younger instructions are in flight:
	// one in the decode register, one on i_instruction and one whose
	// address is on o_pc. all of them get squashed
	localparam int BRANCH_BUBBLES = 3;

endpackage

// ==== src/pat_control.sv ====
`timescale 1ns/1ps

module pat_control #(
	parameter int D_WIDTH = 8,
	parameter int BRANCH_BUBBLES = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic [pat_isa_pkg::I_WIDTH-1:0] i_instruction,
	output logic [pat_isa_pkg::RN_WIDTH-1:0] o_rn,	// decode stage reads
	output logic [pat_isa_pkg::RN_WIDTH-1:0] o_rsel,
	output pat_isa_pkg::operand_sel_e o_operand_sel,
	output logic [D_WIDTH-1:0] o_imm,
	output pat_isa_pkg::alu_op_e o_ex_op,	// execute stage controls
	output logic o_ex_write,
	output logic [pat_isa_pkg::RN_WIDTH-1:0] o_ex_rd,
	output logic o_ex_out,
	output logic o_jump,
	output logic [pat_isa_pkg::IMM8_WIDTH-1:0] o_jump_offset
);

	localparam int SQ_W = (BRANCH_BUBBLES > 1) ? $clog2(BRANCH_BUBBLES + 1) : 1;

	logic [pat_isa_pkg::I_WIDTH-1:0] instr_q;	// decode register
	logic [pat_isa_pkg::OPCODE_WIDTH-1:0] op8;
	logic [pat_isa_pkg::OPCODE_WIDTH-1:0] op3;
	logic [pat_isa_pkg::OPCODE_WIDTH-1:0] op0;
	logic is_i8;
	logic is_i3;
	pat_isa_pkg::alu_op_e dec_op;
	pat_isa_pkg::operand_sel_e dec_sel;
	logic dec_write;
	logic dec_out;
	logic dec_branch;
	logic [SQ_W-1:0] squash_cnt;	// instructions still to kill after a branch
	logic squash;

	// ==================================================
	// decode stage
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			instr_q <= pat_isa_pkg::INSTR_NOP;
		else
			instr_q <= i_instruction;
	end

	assign op8 = instr_q[pat_isa_pkg::OPCODE_I8 +: pat_isa_pkg::OPCODE_WIDTH];
	assign op3 = instr_q[pat_isa_pkg::OPCODE_I3 +: pat_isa_pkg::OPCODE_WIDTH];
	assign op0 = instr_q[pat_isa_pkg::OPCODE_I0 +: pat_isa_pkg::OPCODE_WIDTH];

	assign is_i8 = (op8 != pat_isa_pkg::PREFIX);
	assign is_i3 = !is_i8 && (op3 != pat_isa_pkg::PREFIX);	// otherwise i0 level

	always_comb
	begin
		dec_op = pat_isa_pkg::ALU_PASS_B;
		dec_sel = pat_isa_pkg::SEL_IMM;
		dec_write = 1'b0;
		dec_out = 1'b0;
		dec_branch = 1'b0;
		if (is_i8)
		begin
			dec_sel = op8[0] ? pat_isa_pkg::SEL_REG : pat_isa_pkg::SEL_IMM;	// odd = R form
			dec_write = 1'b1;
			case (pat_isa_pkg::opcode_i8_e'(op8))
				pat_isa_pkg::I8_ORI, pat_isa_pkg::I8_ORR:   dec_op = pat_isa_pkg::ALU_OR;
				pat_isa_pkg::I8_ANDI, pat_isa_pkg::I8_ANDR: dec_op = pat_isa_pkg::ALU_AND;
				pat_isa_pkg::I8_ADDI, pat_isa_pkg::I8_ADDR: dec_op = pat_isa_pkg::ALU_ADD;
				pat_isa_pkg::I8_SUBI, pat_isa_pkg::I8_SUBR: dec_op = pat_isa_pkg::ALU_SUB;
				pat_isa_pkg::I8_LDI: dec_op = pat_isa_pkg::ALU_PASS_B;
				pat_isa_pkg::I8_BF:
				begin
					dec_write = 1'b0;
					dec_branch = 1'b1;	// always taken, no flags
				end
				default: dec_write = 1'b0;	// unknown runs as nop
			endcase
		end
		else if (is_i3)
		begin
			dec_sel = op3[0] ? pat_isa_pkg::SEL_REG : pat_isa_pkg::SEL_IMM;
			dec_write = 1'b1;
			case (pat_isa_pkg::opcode_i3_e'(op3))
				pat_isa_pkg::I3_SHLZI, pat_isa_pkg::I3_SHLZR: dec_op = pat_isa_pkg::ALU_SHLZ;
				pat_isa_pkg::I3_SHLOI, pat_isa_pkg::I3_SHLOR: dec_op = pat_isa_pkg::ALU_SHLO;
				pat_isa_pkg::I3_SHRZI, pat_isa_pkg::I3_SHRZR: dec_op = pat_isa_pkg::ALU_SHRZ;
				pat_isa_pkg::I3_ASRI, pat_isa_pkg::I3_ASRR:   dec_op = pat_isa_pkg::ALU_ASR;
				pat_isa_pkg::I3_IN:
				begin
					dec_op = pat_isa_pkg::ALU_PASS_B;
					dec_sel = pat_isa_pkg::SEL_INPUT;	// one-hot port code in imm3
				end
				pat_isa_pkg::I3_OUT:
				begin
					dec_write = 1'b0;
					dec_out = 1'b1;	// rn goes out on operand a
				end
				default: dec_write = 1'b0;
			endcase
		end
		else if (pat_isa_pkg::opcode_i0_e'(op0) == pat_isa_pkg::I0_NOT)
		begin
			dec_op = pat_isa_pkg::ALU_NOT;
			dec_write = 1'b1;
		end
		// I0_NOP and unknown i0 codes leave everything off
	end

	assign o_rn = instr_q[pat_isa_pkg::RN +: pat_isa_pkg::RN_WIDTH];
	assign o_rsel = instr_q[pat_isa_pkg::IMM3 +: pat_isa_pkg::IMM3_WIDTH];
	assign o_operand_sel = dec_sel;
	assign o_imm = is_i8 ? D_WIDTH'(instr_q[pat_isa_pkg::IMM8 +: pat_isa_pkg::IMM8_WIDTH]) :
		D_WIDTH'(instr_q[pat_isa_pkg::IMM3 +: pat_isa_pkg::IMM3_WIDTH]);

	// ==================================================
	// execute stage registers
	// ==================================================
	// branch in execute kills the decode stage now and the next ones after it
	assign squash = o_jump || (squash_cnt != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			squash_cnt <= '0;
			o_ex_op <= pat_isa_pkg::ALU_PASS_B;
			o_ex_write <= 1'b0;
			o_ex_out <= 1'b0;
			o_jump <= 1'b0;
		end
		else
		begin
			if (o_jump)
				squash_cnt <= SQ_W'(BRANCH_BUBBLES - 1);	// this edge counts as the first
			else if (squash_cnt != '0)
				squash_cnt <= squash_cnt - 1'b1;
			o_ex_op <= dec_op;
			o_ex_write <= dec_write && !squash;
			o_ex_out <= dec_out && !squash;
			o_jump <= dec_branch && !squash;	// single cycle pulse per branch
		end
	end

	always_ff @(posedge clk)
	begin
		o_ex_rd <= o_rn;
		o_jump_offset <= instr_q[pat_isa_pkg::IMM8 +: pat_isa_pkg::IMM8_WIDTH];
	end

	// a branch never writes a register, squash or not
	a_jump_no_write: assert property (@(posedge clk) disable iff (reset)
		!(o_jump && o_ex_write));

endmodule

// ==== src/program_counter.sv ====
`timescale 1ns/1ps

module program_counter #(
	parameter int I_ADR_WIDTH = 10
) (
	input  logic clk,
	input  logic reset,
	input  logic i_jump,	// branch in execute
	input  logic [pat_isa_pkg::IMM8_WIDTH-1:0] i_jump_offset,	// signed
	output logic [I_ADR_WIDTH-1:0] o_pc
);

	localparam int OFS_W = pat_isa_pkg::IMM8_WIDTH;

	logic [I_ADR_WIDTH-1:0] fetch_adr;	// address of word on i_instruction
	logic [I_ADR_WIDTH-1:0] dec_adr;	// address of decode register
	logic [I_ADR_WIDTH-1:0] ex_adr;	// address of execute stage
	logic [I_ADR_WIDTH-1:0] offset_ext;
	logic [I_ADR_WIDTH-1:0] target;

	// ==================================================
	// branch target, relative to the branch itself
	// ==================================================
	assign offset_ext = {{(I_ADR_WIDTH-OFS_W){i_jump_offset[OFS_W-1]}}, i_jump_offset};
	assign target = ex_adr + offset_ext;	// wraps in the address space

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_jump)
			o_pc <= target;
		else
			o_pc <= o_pc + 1'b1;
	end

	// follows each instruction through fetch, decode and execute
	always_ff @(posedge clk)
	begin
		fetch_adr <= o_pc;
		dec_adr <= fetch_adr;
		ex_adr <= dec_adr;
	end

	a_pc_reset: assert property (@(posedge clk) reset |=> (o_pc == '0));

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
	parameter int D_WIDTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic [pat_isa_pkg::RN_WIDTH-1:0] i_rn,	// operand a
	input  logic [pat_isa_pkg::RN_WIDTH-1:0] i_rsel,	// operand b reg, or input code
	input  pat_isa_pkg::operand_sel_e i_operand_sel,
	input  logic [D_WIDTH-1:0] i_imm,
	input  logic [D_WIDTH-1:0] i_in0,
	input  logic [D_WIDTH-1:0] i_in1,
	input  logic [D_WIDTH-1:0] i_in2,
	input  logic i_wr_en,	// write back from execute
	input  logic [pat_isa_pkg::RN_WIDTH-1:0] i_wr_idx,
	input  logic [D_WIDTH-1:0] i_wr_data,
	output logic [D_WIDTH-1:0] o_a,
	output logic [D_WIDTH-1:0] o_b
);

	logic [D_WIDTH-1:0] regs [pat_cfg_pkg::REG_COUNT];
	logic [D_WIDTH-1:0] rn_val;
	logic [D_WIDTH-1:0] rsel_val;
	logic [D_WIDTH-1:0] in_val;
	logic [D_WIDTH-1:0] b_val;

	// ==================================================
	// write back
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < pat_cfg_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (i_wr_en)
			regs[i_wr_idx] <= i_wr_data;
	end

	// ==================================================
	// operand read with bypass from execute
	// ==================================================
	assign rn_val = (i_wr_en && (i_wr_idx == i_rn)) ? i_wr_data : regs[i_rn];
	assign rsel_val = (i_wr_en && (i_wr_idx == i_rsel)) ? i_wr_data : regs[i_rsel];

	// one-hot input port select, anything else reads in0
	always_comb
	begin
		case (i_rsel)
			3'b010:  in_val = i_in1;
			3'b100:  in_val = i_in2;
			default: in_val = i_in0;
		endcase
	end

	always_comb
	begin
		case (i_operand_sel)
			pat_isa_pkg::SEL_REG:   b_val = rsel_val;
			pat_isa_pkg::SEL_INPUT: b_val = in_val;
			default:                b_val = i_imm;	// imm8 or zero extended imm3
		endcase
	end

	// operands into execute
	always_ff @(posedge clk)
	begin
		o_a <= rn_val;
		o_b <= b_val;
	end

	a_wr_idx_known: assert property (@(posedge clk) disable iff (reset)
		i_wr_en |-> !$isunknown(i_wr_idx));

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu #(
	parameter int D_WIDTH = 8
) (
	input  logic clk,
	input  logic reset,
	input  pat_isa_pkg::alu_op_e i_op,
	input  logic [D_WIDTH-1:0] i_a,	// rn
	input  logic [D_WIDTH-1:0] i_b,	// imm, register or input
	input  logic i_out_en,
	output logic [D_WIDTH-1:0] o_result,	// to write back and bypass
	output logic [D_WIDTH-1:0] o_out,
	output logic o_out_valid
);

	logic [2:0] sh;	// shift amount
	logic [D_WIDTH-1:0] ones_fill;
	logic is_sub;
	logic [D_WIDTH-1:0] b_addsub;
	logic [D_WIDTH-1:0] addsub;

	// ==================================================
	// shared adder, sub is a + ~b + 1
	// ==================================================
	assign is_sub = (i_op == pat_isa_pkg::ALU_SUB);
	assign b_addsub = is_sub ? ~i_b : i_b;
	assign addsub = i_a + b_addsub + D_WIDTH'(is_sub);	// wraps at D_WIDTH

	// only the low three bits count, register shifts included
	assign sh = i_b[2:0];
	assign ones_fill = ~({D_WIDTH{1'b1}} << sh);	// ones in the vacated low bits

	always_comb
	begin
		case (i_op)
			pat_isa_pkg::ALU_OR:   o_result = i_a | i_b;
			pat_isa_pkg::ALU_AND:  o_result = i_a & i_b;
			pat_isa_pkg::ALU_ADD,
			pat_isa_pkg::ALU_SUB:  o_result = addsub;
			pat_isa_pkg::ALU_SHLZ: o_result = i_a << sh;
			pat_isa_pkg::ALU_SHLO: o_result = (i_a << sh) | ones_fill;
			pat_isa_pkg::ALU_SHRZ: o_result = i_a >> sh;
			pat_isa_pkg::ALU_ASR:  o_result = $unsigned($signed(i_a) >>> sh);	// sign fill
			pat_isa_pkg::ALU_NOT:  o_result = ~i_a;
			default:               o_result = i_b;	// pass b, ldi and in
		endcase
	end

	// ==================================================
	// output port
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			o_out_valid <= 1'b0;
		else
			o_out_valid <= i_out_en;	// one cycle per out
	end

	always_ff @(posedge clk)
	begin
		if (i_out_en)
			o_out <= i_a;	// holds last value between strobes
	end

endmodule

// ==== src/pat_top.sv ====
`timescale 1ns/1ps

module pat_top #(
	parameter int D_WIDTH = pat_cfg_pkg::D_WIDTH,
	parameter int I_ADR_WIDTH = pat_cfg_pkg::I_ADR_WIDTH,
	parameter int BRANCH_BUBBLES = pat_cfg_pkg::BRANCH_BUBBLES
) (
	input  logic clk,
	input  logic reset,
	input  logic [pat_isa_pkg::I_WIDTH-1:0] i_instruction,	// one cycle after o_pc
	input  logic [D_WIDTH-1:0] i_in0,
	input  logic [D_WIDTH-1:0] i_in1,
	input  logic [D_WIDTH-1:0] i_in2,
	output logic [I_ADR_WIDTH-1:0] o_pc,
	output logic [D_WIDTH-1:0] o_out,
	output logic o_out_valid,
	output logic o_jump
);

	// decode stage
	logic [pat_isa_pkg::RN_WIDTH-1:0] rn;
	logic [pat_isa_pkg::RN_WIDTH-1:0] rsel;
	pat_isa_pkg::operand_sel_e operand_sel;
	logic [D_WIDTH-1:0] imm;

	// execute stage
	pat_isa_pkg::alu_op_e ex_op;
	logic ex_write;
	logic [pat_isa_pkg::RN_WIDTH-1:0] ex_rd;
	logic ex_out;
	logic [pat_isa_pkg::IMM8_WIDTH-1:0] jump_offset;
	logic [D_WIDTH-1:0] op_a;
	logic [D_WIDTH-1:0] op_b;
	logic [D_WIDTH-1:0] result;

	pat_control #(.D_WIDTH(D_WIDTH), .BRANCH_BUBBLES(BRANCH_BUBBLES)) i_pat_control (
		.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.o_rn(rn), .o_rsel(rsel), .o_operand_sel(operand_sel), .o_imm(imm),
		.o_ex_op(ex_op), .o_ex_write(ex_write), .o_ex_rd(ex_rd), .o_ex_out(ex_out),
		.o_jump(o_jump), .o_jump_offset(jump_offset)
	);

	program_counter #(.I_ADR_WIDTH(I_ADR_WIDTH)) i_program_counter (
		.clk(clk), .reset(reset),
		.i_jump(o_jump), .i_jump_offset(jump_offset),
		.o_pc(o_pc)
	);

	register_file #(.D_WIDTH(D_WIDTH)) i_register_file (
		.clk(clk), .reset(reset),
		.i_rn(rn), .i_rsel(rsel), .i_operand_sel(operand_sel), .i_imm(imm),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.i_wr_en(ex_write), .i_wr_idx(ex_rd), .i_wr_data(result),
		.o_a(op_a), .o_b(op_b)
	);

	alu #(.D_WIDTH(D_WIDTH)) i_alu (
		.clk(clk), .reset(reset),
		.i_op(ex_op), .i_a(op_a), .i_b(op_b), .i_out_en(ex_out),
		.o_result(result), .o_out(o_out), .o_out_valid(o_out_valid)
	);

endmodule

// ==== test/pat_programs.svh ====
`ifndef PAT_PROGRAMS_SVH
`define PAT_PROGRAMS_SVH

// ==================================================
// program table with one entry per row index
// ==================================================
localparam int NUM_ENTRIES = 7;
localparam int MAX_WORDS = 40;
localparam int MAX_OUTS = 16;

logic [pat_isa_pkg::I_WIDTH-1:0] prog_rom [NUM_ENTRIES][MAX_WORDS];
int prog_len [NUM_ENTRIES];
logic [7:0] exp_out [NUM_ENTRIES][MAX_OUTS];	// o_out values in order
int exp_count [NUM_ENTRIES];
int exp_jumps [NUM_ENTRIES];	// -1 for a parked core whose count keeps growing
logic [7:0] in_vals [NUM_ENTRIES][3];

task automatic add_word(input int e, input logic [pat_isa_pkg::I_WIDTH-1:0] w);
	prog_rom[e][prog_len[e]] = w;
	prog_len[e]++;
endtask

task automatic add_expected(input int e, input logic [7:0] v);
	exp_out[e][exp_count[e]] = v;
	exp_count[e]++;
endtask

task automatic load_table();
	for (int e = 0; e < NUM_ENTRIES; e++)
	begin
		prog_len[e] = 0;
		exp_count[e] = 0;
		exp_jumps[e] = 0;
		in_vals[e][0] = 8'h00;
		in_vals[e][1] = 8'h00;
		in_vals[e][2] = 8'h00;
	end
	// entry 0 covers logic and arithmetic in immediate then register forms
	add_word(0, enc_i8(pat_isa_pkg::I8_LDI, 1, 8'h5a));
	add_word(0, enc_i8(pat_isa_pkg::I8_ORI, 1, 8'h81));
	add_expected(0, 8'hdb);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_ANDI, 1, 8'h0f));
	add_expected(0, 8'h0b);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_ADDI, 1, 8'hff));
	add_expected(0, 8'h0a);	// wraps
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_SUBI, 1, 8'h0c));
	add_expected(0, 8'hfe);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_LDI, 2, 8'h33));
	add_word(0, enc_i8(pat_isa_pkg::I8_ORR, 1, 8'd2));
	add_expected(0, 8'hff);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_ANDR, 1, 8'd2));
	add_expected(0, 8'h33);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_ADDR, 1, 8'd2));
	add_expected(0, 8'h66);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(0, enc_i8(pat_isa_pkg::I8_SUBR, 2, 8'd1));
	add_expected(0, 8'hcd);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 2, 0));
	add_word(0, enc_i0(pat_isa_pkg::I0_NOT, 2));
	add_expected(0, 8'h32);
	add_word(0, enc_i3(pat_isa_pkg::I3_OUT, 2, 0));
	// entry 1 covers shifts on 0x96 with the sign bit set
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHLZI, 3, 3'd2));
	add_expected(1, 8'h58);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHLOI, 3, 3'd3));
	add_expected(1, 8'hb7);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHRZI, 3, 3'd1));
	add_expected(1, 8'h4b);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_ASRI, 3, 3'd2));
	add_expected(1, 8'he5);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	// register amounts carry junk above bit 2
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 4, 8'h0a));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHLZR, 3, 3'd4));
	add_expected(1, 8'h58);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 4, 8'h0b));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHLOR, 3, 3'd4));
	add_expected(1, 8'hb7);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 4, 8'hf9));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_SHRZR, 3, 3'd4));
	add_expected(1, 8'h4b);
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 4, 8'h0d));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h96));
	add_word(1, enc_i3(pat_isa_pkg::I3_ASRR, 3, 3'd4));
	add_expected(1, 8'hfc);	// amount 5
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	add_word(1, enc_i8(pat_isa_pkg::I8_LDI, 3, 8'h74));
	add_word(1, enc_i3(pat_isa_pkg::I3_ASRI, 3, 3'd7));
	add_expected(1, 8'h00);	// positive
	add_word(1, enc_i3(pat_isa_pkg::I3_OUT, 3, 0));
	// entry 2 runs dependent chains with both operands bypassed
	add_word(2, enc_i8(pat_isa_pkg::I8_LDI, 0, 8'h01));
	add_word(2, enc_i8(pat_isa_pkg::I8_ADDR, 0, 8'd0));
	add_word(2, enc_i8(pat_isa_pkg::I8_ADDR, 0, 8'd0));
	add_word(2, enc_i8(pat_isa_pkg::I8_ADDR, 0, 8'd0));
	add_expected(2, 8'h08);
	add_word(2, enc_i3(pat_isa_pkg::I3_OUT, 0, 0));
	add_word(2, enc_i8(pat_isa_pkg::I8_LDI, 5, 8'h10));
	add_word(2, enc_i8(pat_isa_pkg::I8_LDI, 6, 8'h03));
	add_word(2, enc_i8(pat_isa_pkg::I8_ADDR, 6, 8'd5));
	add_word(2, enc_i8(pat_isa_pkg::I8_SUBR, 5, 8'd6));
	add_expected(2, 8'hfd);
	add_word(2, enc_i3(pat_isa_pkg::I3_OUT, 5, 0));
	add_expected(2, 8'h13);
	add_word(2, enc_i3(pat_isa_pkg::I3_OUT, 6, 0));
	add_word(2, enc_i0(pat_isa_pkg::I0_NOT, 5));
	add_word(2, enc_i8(pat_isa_pkg::I8_ADDI, 5, 8'h01));
	add_expected(2, 8'h03);
	add_word(2, enc_i3(pat_isa_pkg::I3_OUT, 5, 0));
	// entry 3 takes two forward branches and the skipped outs stay silent
	add_word(3, enc_i8(pat_isa_pkg::I8_LDI, 1, 8'h11));
	add_expected(3, 8'h11);
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i8(pat_isa_pkg::I8_BF, 0, 8'd4));	// to 6
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i8(pat_isa_pkg::I8_LDI, 1, 8'h99));
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i8(pat_isa_pkg::I8_ADDI, 1, 8'h01));
	add_expected(3, 8'h12);
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i8(pat_isa_pkg::I8_BF, 0, 8'd3));	// to 11
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(3, enc_i8(pat_isa_pkg::I8_LDI, 2, 8'h77));
	add_expected(3, 8'h77);
	add_word(3, enc_i3(pat_isa_pkg::I3_OUT, 2, 0));
	exp_jumps[3] = 2;
	// entry 4 parks on a branch to itself
	add_word(4, enc_i8(pat_isa_pkg::I8_LDI, 1, 8'h42));
	add_expected(4, 8'h42);
	add_word(4, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(4, enc_i8(pat_isa_pkg::I8_BF, 0, 8'd0));
	add_word(4, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	exp_jumps[4] = -1;
	// entry 5 branches forward then backward then parks
	add_word(5, enc_i8(pat_isa_pkg::I8_BF, 0, 8'd4));	// to 4
	add_word(5, enc_i8(pat_isa_pkg::I8_LDI, 2, 8'h21));
	add_word(5, enc_i3(pat_isa_pkg::I3_OUT, 2, 0));
	add_word(5, enc_i8(pat_isa_pkg::I8_BF, 0, 8'd0));
	add_word(5, enc_i3(pat_isa_pkg::I3_OUT, 2, 0));
	add_expected(5, 8'h00);
	add_word(5, enc_i8(pat_isa_pkg::I8_BF, 0, 8'hfc));	// back to 1
	add_expected(5, 8'h21);
	exp_jumps[5] = -1;
	// entry 6 checks one-hot input select where other codes read in0
	in_vals[6][0] = 8'h3c;
	in_vals[6][1] = 8'ha5;
	in_vals[6][2] = 8'h7e;
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b001));
	add_expected(6, 8'h3c);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b010));
	add_expected(6, 8'ha5);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b100));
	add_expected(6, 8'h7e);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b000));
	add_expected(6, 8'h3c);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b011));
	add_expected(6, 8'h3c);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
	add_word(6, enc_i3(pat_isa_pkg::I3_IN, 1, 3'b111));
	add_expected(6, 8'h3c);
	add_word(6, enc_i3(pat_isa_pkg::I3_OUT, 1, 0));
endtask

`endif

// ==== test/pat_tb.sv ====
`timescale 1ns/1ps

module pat_tb;

	localparam int D_WIDTH = pat_cfg_pkg::D_WIDTH;
	localparam int I_ADR_WIDTH = pat_cfg_pkg::I_ADR_WIDTH;
	localparam int WATCH_CYCLES = 20;	// quiet time after the last expected strobe
	localparam int WAIT_LIMIT = 100;	// cycles allowed between two strobes

	logic clk;
	logic reset;
	logic [pat_isa_pkg::I_WIDTH-1:0] i_instruction;
	logic [D_WIDTH-1:0] i_in0;
	logic [D_WIDTH-1:0] i_in1;
	logic [D_WIDTH-1:0] i_in2;
	logic [I_ADR_WIDTH-1:0] o_pc;
	logic [D_WIDTH-1:0] o_out;
	logic o_out_valid;
	logic o_jump;

	int cur;	// table entry being served
	int cyc;	// cycles since reset release
	int jump_count;
	logic prev_jump;

	// ==================================================
	// instruction encoders, bits 19..12 stay zero
	// ==================================================
	function automatic logic [pat_isa_pkg::I_WIDTH-1:0] enc_i8(
		input pat_isa_pkg::opcode_i8_e op, input logic [2:0] rn, input logic [7:0] imm);
		return {rn, 8'h00, 4'(op), imm};
	endfunction

	function automatic logic [pat_isa_pkg::I_WIDTH-1:0] enc_i3(
		input pat_isa_pkg::opcode_i3_e op, input logic [2:0] rn, input logic [2:0] imm);
		return {rn, 8'h00, pat_isa_pkg::PREFIX, 4'(op), 1'b0, imm};	// bit 3 unused
	endfunction

	function automatic logic [pat_isa_pkg::I_WIDTH-1:0] enc_i0(
		input pat_isa_pkg::opcode_i0_e op, input logic [2:0] rn);
		return {rn, 8'h00, pat_isa_pkg::PREFIX, pat_isa_pkg::PREFIX, 4'(op)};
	endfunction

	`include "pat_programs.svh"

	pat_top #(
		.D_WIDTH(D_WIDTH),
		.I_ADR_WIDTH(I_ADR_WIDTH),
		.BRANCH_BUBBLES(pat_cfg_pkg::BRANCH_BUBBLES)
	) i_pat_top (
		.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_in0(i_in0), .i_in1(i_in1), .i_in2(i_in2),
		.o_pc(o_pc), .o_out(o_out), .o_out_valid(o_out_valid), .o_jump(o_jump)
	);

	always #20 clk = ~clk;	// 40 ns period

	// ==================================================
	// instruction server, word for o_pc shows up one edge later
	// ==================================================
	always @(posedge clk)
	begin
		if (reset)
			i_instruction <= pat_isa_pkg::INSTR_NOP;	// o_pc sits at 0 during reset
		else if (int'(o_pc) < prog_len[cur])
			i_instruction <= prog_rom[cur][o_pc[5:0]];
		else
			i_instruction <= pat_isa_pkg::INSTR_NOP;	// ran off the end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, msg, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	endtask

	// one cycle, sampled at the falling edge where outputs are settled
	task automatic step_cycle();
		@(negedge clk);
		if (cyc == 0)
		begin
			check_value(32'(o_out_valid), 0, "o_out_valid right after reset");
			check_value(32'(o_jump), 0, "o_jump right after reset");
		end
		if (cyc < 3)
			check_value(32'(o_pc), 32'(cyc), "o_pc counting from reset");	// no branch yet
		if (o_jump)
		begin
			check_value(32'(prev_jump), 0, "o_jump wider than one cycle");
			jump_count++;
		end
		prev_jump = o_jump;
		cyc++;
	endtask

	// ==================================================
	// run one table entry
	// ==================================================
	task automatic run_entry(input int e);
		int got;
		int waited;
		@(posedge clk);
		reset <= 1'b1;
		cur = e;
		i_in0 <= in_vals[e][0];
		i_in1 <= in_vals[e][1];
		i_in2 <= in_vals[e][2];
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		cyc = 0;
		jump_count = 0;
		prev_jump = 1'b0;
		got = 0;
		while (got < exp_count[e])
		begin
			waited = 0;
			step_cycle();
			while (!o_out_valid)
			begin
				if (waited == WAIT_LIMIT)
					timeout_fail($sformatf("o_out_valid number %0d of entry %0d", got, e));
				step_cycle();
				waited++;
			end
			check_value(32'(o_out), 32'(exp_out[e][got]),
				$sformatf("entry %0d out value %0d", e, got));
			got++;
		end
		// nothing more may come out
		repeat (WATCH_CYCLES)
		begin
			step_cycle();
			check_value(32'(o_out_valid), 0, $sformatf("extra o_out strobe in entry %0d", e));
		end
		if (exp_jumps[e] >= 0)
			check_value(32'(jump_count), 32'(exp_jumps[e]),
				$sformatf("o_jump count in entry %0d", e));
		else
			check_value(32'(jump_count > 0), 1, $sformatf("parking branch in entry %0d", e));
	endtask

	initial
	begin
		clk = 1'b0;
		cur = 0;
		cyc = 0;
		jump_count = 0;
		prev_jump = 1'b0;
		reset <= 1'b1;
		i_instruction <= pat_isa_pkg::INSTR_NOP;
		i_in0 <= '0;
		i_in1 <= '0;
		i_in2 <= '0;
		load_table();
		for (int e = 0; e < NUM_ENTRIES; e++)
			run_entry(e);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// ==== pat.f ====
+incdir+test
src/pat_isa_pkg.sv
src/pat_cfg_pkg.sv
src/pat_control.sv
src/program_counter.sv
src/register_file.sv
src/alu.sv
src/pat_top.sv
test/pat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pat testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pat_tb -f pat.f

# the simulation exits non-zero on failure, the log decides
./obj_dir/Vpat_tb | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	echo "run_sim: pass"
	exit 0
else
	echo "run_sim: fail"
	exit 1
fi
